// File: Bender.yml
package:
  name: floppy_fdc

sources:
  - files:
      - fdc_pkg.sv
      - drq_watchdog.sv
      - sector_buffer.sv
      - fdc_core.sv
      - floppy_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_floppy.sv

// File: build.f
+incdir+.
fdc_pkg.sv
drq_watchdog.sv
sector_buffer.sv
fdc_core.sv
floppy_top.sv
tb_floppy.sv

// File: drq_watchdog.sv
`timescale 1ns/1ps

module drq_watchdog (
	input  logic clk,
	input  logic cock,
	input  logic restart, // one pulse as drq rises
	output logic bark     // drq unserved for too long
);

	logic [fdc_pkg::DOG_W-1:0] count;

	// counts down to zero and parks there
	always_ff @(posedge clk or posedge cock) begin
		if (cock) begin
			count <= '0;
		end else if (restart) begin
			count <= fdc_pkg::WATCHDOG_TIME[fdc_pkg::DOG_W-1:0];
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	assign bark = (count == '0); // high until the next restart

endmodule

// File: fdc_core.sv
`timescale 1ns/1ps

module fdc_core (
	input  logic                        clk,
	input  logic                        cock,
	input  fdc_pkg::host_bus_t          host,
	output logic [7:0]                  rdata,
	output logic                        irq,
	output logic                        drq,
	output logic                        req_valid,   // one cycle per request
	output fdc_pkg::fdc_request_t       req,         // held until the next request
	input  logic                        reply_valid,
	input  fdc_pkg::fdc_reply_t         reply,
	output logic [fdc_pkg::BUF_AW-1:0]  buf_addr,
	output logic                        buf_rd,
	input  logic [7:0]                  buf_data,
	output logic                        dog_restart,
	input  logic                        dog_bark
);

	typedef enum logic [2:0] {
		S_IDLE,       // also serves drq to the host
		S_WAIT_REPLY,
		S_FETCH,
		S_DELAY,
		S_NEXT_ADDR,
		S_ABORT
	} state_e;

	state_e state;

	logic [7:0] track_reg;
	logic [7:0] sector_reg;
	logic [7:0] data_reg;
	logic [7:0] head;        // real head position, ff = unknown
	logic       step_dir;    // 1 = out, toward track 0
	logic       side;
	logic       drive;
	logic       busy;
	logic       seek_err;
	logic       lost;
	logic       head_loaded;
	logic       type2;       // layout of the status byte
	logic       multi;
	logic [fdc_pkg::CNT_W-1:0]   byte_cnt; // bytes left, current one included
	logic [fdc_pkg::FETCH_W-1:0] fetch_timer;
	logic [7:0] status;

	logic [3:0] cmd;
	logic       cmd_wr;
	logic       force_int;
	logic       data_rd;
	logic       byte_done;
	logic       step_out;
	logic [7:0] head_step;

	assign cmd       = host.wdata[7:4];
	assign cmd_wr    = host.wr && (host.addr == fdc_pkg::A_STATUS_CMD);
	assign force_int = cmd_wr && (cmd == fdc_pkg::CMD_FORCE_INT); // accepted even when busy
	assign data_rd   = host.rd && (host.addr == fdc_pkg::A_DATA);
	// host took the byte, or the watchdog gave up on it
	assign byte_done = (state == S_IDLE) && drq && (data_rd || dog_bark);
	assign step_out  = host.wdata[6] ? host.wdata[5] : step_dir; // plain step keeps last dir
	assign head_step = step_out ? head - 8'd1 : head + 8'd1;
	assign dog_restart = (state == S_DELAY) && (fetch_timer == '0) && !force_int;

	// --------------------------------------------------
	// status byte
	// --------------------------------------------------
	always_comb begin
		status = '0;
		status[fdc_pkg::SBIT_BUSY]     = busy;
		status[fdc_pkg::SBIT_SEEKERR]  = seek_err;
		status[fdc_pkg::SBIT_CRC]      = 1'b0; // no crc on an image
		status[fdc_pkg::SBIT_READONLY] = 1'b0;
		status[fdc_pkg::SBIT_NOTREADY] = 1'b0; // drive always there
		if (type2) begin
			status[fdc_pkg::SBIT_DRQ_INDEX]   = drq;
			status[fdc_pkg::SBIT_LOST_TRACK0] = lost;
		end else begin
			status[fdc_pkg::SBIT_LOST_TRACK0] = (head == 8'd0);
			status[fdc_pkg::SBIT_HEADLOAD]    = head_loaded; // index pulse not modeled
		end
	end

	// request word, track is always the head position
	function automatic fdc_pkg::fdc_request_t make_req(input fdc_pkg::req_kind_e kind,
		input logic [3:0] nib, input logic [7:0] sec);
		fdc_pkg::fdc_request_t r;
		r.kind   = kind;
		r.cmd    = nib;
		r.drive  = drive;
		r.side   = side;
		r.track  = head;
		r.sector = sec;
		return r;
	endfunction

	always_ff @(posedge clk or posedge cock) begin
		if (cock) begin
			state       <= S_IDLE;
			track_reg   <= '0;
			sector_reg  <= '0;
			data_reg    <= '0;
			head        <= 8'hff;
			step_dir    <= 1'b0;
			{side, drive} <= 2'b00;
			{busy, seek_err, lost, head_loaded} <= '0;
			{type2, multi} <= 2'b00;
			byte_cnt    <= '0;
			fetch_timer <= '0;
			rdata       <= '0;
			{irq, drq}  <= 2'b00;
			req_valid   <= 1'b0;
			req         <= '0;
			buf_addr    <= '0;
			buf_rd      <= 1'b0;
		end else begin
			req_valid <= 1'b0; // strobes
			buf_rd    <= 1'b0;

			// --------------------------------------------------
			// host register access
			// --------------------------------------------------
			if (host.rd) begin
				case (host.addr)
				fdc_pkg::A_STATUS_CMD: rdata <= status;
				fdc_pkg::A_TRACK:      rdata <= track_reg;
				fdc_pkg::A_SECTOR:     rdata <= sector_reg;
				fdc_pkg::A_DATA:       rdata <= data_reg;
				fdc_pkg::A_CTL2:       rdata <= {5'b11111, side, 1'b0, drive};
				default:               rdata <= 8'hff;
				endcase
			end

			if (host.wr) begin
				case (host.addr)
				fdc_pkg::A_TRACK:  if (!busy) track_reg <= host.wdata;
				fdc_pkg::A_SECTOR: if (!busy) sector_reg <= host.wdata;
				fdc_pkg::A_DATA:   data_reg <= host.wdata; // seek target
				fdc_pkg::A_CTL2: begin
					side  <= host.wdata[2];
					drive <= host.wdata[0];
				end
				default: ;
				endcase
			end

			// new command, only when idle
			if (cmd_wr && !force_int && !busy) begin
				type2     <= host.wdata[7];
				busy      <= 1'b1;
				irq       <= 1'b0;
				seek_err  <= 1'b0;
				lost      <= 1'b0;
				req_valid <= 1'b1;
				state     <= S_WAIT_REPLY;
				req       <= make_req(fdc_pkg::REQ_NOP, cmd, sector_reg);
				case (cmd)
				fdc_pkg::CMD_RESTORE: begin
					head        <= 8'd0;
					track_reg   <= 8'd0;
					head_loaded <= host.wdata[3];
				end
				fdc_pkg::CMD_SEEK: begin
					head        <= data_reg;
					track_reg   <= data_reg;
					head_loaded <= host.wdata[3];
				end
				fdc_pkg::CMD_STEP, fdc_pkg::CMD_STEP_U,
				fdc_pkg::CMD_STEP_IN, fdc_pkg::CMD_STEP_IN_U,
				fdc_pkg::CMD_STEP_OUT, fdc_pkg::CMD_STEP_OUT_U: begin
					step_dir    <= step_out;
					head        <= head_step;
					head_loaded <= host.wdata[3];
					if (host.wdata[4])
						track_reg <= head_step; // update flag
				end
				fdc_pkg::CMD_READ_SEC, fdc_pkg::CMD_READ_MULTI: begin
					multi    <= host.wdata[4];
					byte_cnt <= fdc_pkg::SECTOR_SIZE[fdc_pkg::CNT_W-1:0];
					req      <= make_req(fdc_pkg::REQ_READ, cmd, sector_reg);
				end
				fdc_pkg::CMD_READ_ADDR: begin
					multi    <= 1'b0;
					byte_cnt <= fdc_pkg::READADDR_LEN[fdc_pkg::CNT_W-1:0];
					req      <= make_req(fdc_pkg::REQ_READADDR, cmd, sector_reg);
				end
				default: ; // writes and track ops, just a nop round trip
				endcase
			end

			// --------------------------------------------------
			// command FSM
			// --------------------------------------------------
			if (force_int) begin
				state <= S_ABORT;
			end else begin
				case (state)
				S_IDLE: if (byte_done) begin
					drq <= 1'b0;
					if (!data_rd)
						lost <= 1'b1; // watchdog, skip this byte
					if (byte_cnt == 1) begin
						if (multi && sector_reg <= fdc_pkg::SECTORS_PER_TRACK) begin
							sector_reg <= sector_reg + 8'd1;
							byte_cnt   <= fdc_pkg::SECTOR_SIZE[fdc_pkg::CNT_W-1:0];
							req_valid  <= 1'b1;
							req        <= make_req(fdc_pkg::REQ_READ, req.cmd,
								sector_reg + 8'd1);
							state      <= S_WAIT_REPLY;
						end else begin
							busy  <= 1'b0;
							irq   <= 1'b1;
							multi <= 1'b0;
						end
					end else begin
						state <= S_NEXT_ADDR;
					end
				end
				S_WAIT_REPLY: if (reply_valid && reply.done) begin
					if (!reply.ok) begin
						seek_err <= 1'b1; // record not found in type II
						busy     <= 1'b0;
						irq      <= 1'b1;
						multi    <= 1'b0;
						state    <= S_IDLE;
					end else if (req.kind == fdc_pkg::REQ_NOP) begin
						busy  <= 1'b0;
						irq   <= 1'b1;
						state <= S_IDLE;
					end else begin
						buf_addr <= '0; // buffer is full, start at byte 0
						state    <= S_FETCH;
					end
				end
				S_FETCH: begin
					buf_rd      <= 1'b1;
					fetch_timer <= fdc_pkg::FETCH_DELAY[fdc_pkg::FETCH_W-1:0];
					state       <= S_DELAY;
				end
				S_DELAY: begin
					if (fetch_timer != '0) begin
						fetch_timer <= fetch_timer - 1'b1;
					end else begin
						data_reg <= buf_data;
						drq      <= 1'b1;
						state    <= S_IDLE;
					end
				end
				S_NEXT_ADDR: begin
					buf_addr <= buf_addr + 1'b1;
					byte_cnt <= byte_cnt - 1'b1;
					state    <= S_FETCH;
				end
				S_ABORT: begin
					busy     <= 1'b0;
					drq      <= 1'b0;
					seek_err <= 1'b0;
					lost     <= 1'b0;
					multi    <= 1'b0;
					state    <= S_IDLE; // a late reply is ignored from here
				end
				default: state <= S_IDLE;
				endcase
			end
		end
	end

endmodule

// File: fdc_pkg.sv
package fdc_pkg;

	// --------------------------------------------------
	// host register map
	// --------------------------------------------------
	localparam logic [2:0] A_STATUS_CMD = 3'd0; // status on read, command on write
	localparam logic [2:0] A_TRACK      = 3'd1;
	localparam logic [2:0] A_SECTOR     = 3'd2;
	localparam logic [2:0] A_DATA       = 3'd3;
	localparam logic [2:0] A_CTL2       = 3'd7; // bit0 drive, bit2 side

	// command nibbles, bits 7:4 of the command byte
	localparam logic [3:0] CMD_RESTORE    = 4'h0;
	localparam logic [3:0] CMD_SEEK       = 4'h1;
	localparam logic [3:0] CMD_STEP       = 4'h2;
	localparam logic [3:0] CMD_STEP_U     = 4'h3; // _U variants update the track register
	localparam logic [3:0] CMD_STEP_IN    = 4'h4;
	localparam logic [3:0] CMD_STEP_IN_U  = 4'h5;
	localparam logic [3:0] CMD_STEP_OUT   = 4'h6;
	localparam logic [3:0] CMD_STEP_OUT_U = 4'h7;
	localparam logic [3:0] CMD_READ_SEC   = 4'h8;
	localparam logic [3:0] CMD_READ_MULTI = 4'h9;
	localparam logic [3:0] CMD_READ_ADDR  = 4'hC;
	localparam logic [3:0] CMD_FORCE_INT  = 4'hD;

	// sizes and timing
	localparam int SECTOR_SIZE       = 1024;
	localparam int SECTORS_PER_TRACK = 5;
	localparam int READADDR_LEN      = 6;   // track, side, sector, size code, crc x2
	localparam int FETCH_DELAY       = 4;   // wait states between buffer read and drq
	localparam int WATCHDOG_TIME     = 255; // cycles drq may stay unserved

	localparam int BUF_AW  = $clog2(SECTOR_SIZE);
	localparam int CNT_W   = BUF_AW + 1;    // byte counter holds a full sector
	localparam int FETCH_W = $clog2(FETCH_DELAY + 1);
	localparam int DOG_W   = $clog2(WATCHDOG_TIME + 1);

	// status bits; several are shared between the type I and type II layouts
	localparam int SBIT_BUSY        = 0;
	localparam int SBIT_DRQ_INDEX   = 1; // drq in type II, index in type I
	localparam int SBIT_LOST_TRACK0 = 2; // lost data in type II, track 0 in type I
	localparam int SBIT_CRC         = 3;
	localparam int SBIT_SEEKERR     = 4; // record not found in type II
	localparam int SBIT_HEADLOAD    = 5;
	localparam int SBIT_READONLY    = 6;
	localparam int SBIT_NOTREADY    = 7;

	// --------------------------------------------------
	// bundles
	// --------------------------------------------------
	typedef enum logic [1:0] {
		REQ_NOP,
		REQ_READ,
		REQ_READADDR
	} req_kind_e;

	typedef struct packed {
		logic       rd;
		logic       wr;
		logic [2:0] addr;
		logic [7:0] wdata;
	} host_bus_t;

	typedef struct packed {
		req_kind_e  kind;
		logic [3:0] cmd;    // command nibble, for nop requests
		logic       drive;
		logic       side;
		logic [7:0] track;  // head position, not the track register
		logic [7:0] sector;
	} fdc_request_t;

	typedef struct packed {
		logic done;
		logic ok;
	} fdc_reply_t;

	typedef struct packed {
		logic              en;
		logic [BUF_AW-1:0] addr;
		logic [7:0]        data;
	} buf_write_t;

endpackage

// File: floppy_top.sv
`timescale 1ns/1ps

module floppy_top (
	input  logic                  clk,
	input  logic                  cock,
	input  fdc_pkg::host_bus_t    host,
	output logic [7:0]            rdata,
	output logic                  irq,
	output logic                  drq,
	output logic                  req_valid,   // to the workhorse
	output fdc_pkg::fdc_request_t req,
	input  logic                  reply_valid, // from the workhorse
	input  fdc_pkg::fdc_reply_t   reply,
	input  fdc_pkg::buf_write_t   buf_wr       // workhorse fills the sector here
);

	// core to buffer
	logic [fdc_pkg::BUF_AW-1:0] buf_addr;
	logic                       buf_rd;
	logic [7:0]                 buf_data;

	// core to watchdog
	logic dog_restart;
	logic dog_bark;

	// --------------------------------------------------
	// register file and FSM
	// --------------------------------------------------
	fdc_core core_inst (
		.clk         (clk),
		.cock        (cock),
		.host        (host),
		.rdata       (rdata),
		.irq         (irq),
		.drq         (drq),
		.req_valid   (req_valid),
		.req         (req),
		.reply_valid (reply_valid),
		.reply       (reply),
		.buf_addr    (buf_addr),
		.buf_rd      (buf_rd),
		.buf_data    (buf_data),
		.dog_restart (dog_restart),
		.dog_bark    (dog_bark)
	);

	drq_watchdog dog_inst (
		.clk     (clk),
		.cock    (cock),
		.restart (dog_restart),
		.bark    (dog_bark)
	);

	sector_buffer buf_inst (
		.clk     (clk),
		.wr      (buf_wr),
		.rd_addr (buf_addr),
		.rd_en   (buf_rd),
		.rd_data (buf_data)
	);

endmodule

// File: sector_buffer.sv
`timescale 1ns/1ps

// one sector of data between the workhorse and the controller
module sector_buffer (
	input  logic                       clk,
	input  fdc_pkg::buf_write_t        wr,      // workhorse side
	input  logic [fdc_pkg::BUF_AW-1:0] rd_addr, // controller side
	input  logic                       rd_en,
	output logic [7:0]                 rd_data
);

	logic [7:0] mem [fdc_pkg::SECTOR_SIZE];

	// --------------------------------------------------
	// write port, any rate
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (wr.en)
			mem[wr.addr] <= wr.data;
	end

	// --------------------------------------------------
	// read port, data one cycle after rd_en
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_data <= mem[rd_addr]; // holds until next rd_en
	end

endmodule

// File: tb_floppy_tasks.svh
`ifndef TB_FLOPPY_TASKS_SVH
`define TB_FLOPPY_TASKS_SVH

// --------------------------------------------------
// register model
// --------------------------------------------------
logic [7:0] m_track;  // track register
logic [7:0] m_sector; // sector register
logic [7:0] m_head;   // head position, ff = unknown
logic       m_dir;    // 1 = out, toward track 0
logic       m_drive;
logic       m_side;

// byte i of a sector in the disk image
function automatic logic [7:0] pattern_byte(input int i, input logic [7:0] trk,
	input logic [7:0] sec);
	return (i[7:0] ^ trk) + sec * 8'd37;
endfunction

// head and track after a type I command
task automatic apply_type1(input logic [3:0] nib, input logic [7:0] target);
	case (nib)
	fdc_pkg::CMD_RESTORE: begin
		m_head  = 8'd0;
		m_track = 8'd0;
	end
	fdc_pkg::CMD_SEEK: begin
		m_head  = target;
		m_track = target;
	end
	default: begin // step family
		if (nib >= fdc_pkg::CMD_STEP_OUT)
			m_dir = 1'b1;
		else if (nib >= fdc_pkg::CMD_STEP_IN)
			m_dir = 1'b0;
		// plain step keeps the last direction
		m_head = m_dir ? m_head - 8'd1 : m_head + 8'd1;
		if (nib[0])
			m_track = m_head; // odd nibbles update
	end
	endcase
endtask

// request as the workhorse should see it, head taken before the command
function automatic fdc_pkg::fdc_request_t expect_req(input fdc_pkg::req_kind_e kind,
	input logic [3:0] nib, input logic [7:0] sec);
	fdc_pkg::fdc_request_t r;
	r.kind   = kind;
	r.cmd    = nib;
	r.drive  = m_drive;
	r.side   = m_side;
	r.track  = m_head;
	r.sector = sec;
	return r;
endfunction

// --------------------------------------------------
// error counting and compares
// --------------------------------------------------
task automatic report_error(input string what);
	$display("error at %0t: %s", $time, what);
	test_errors++;
	n_errors++;
endtask

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
	n_checks++;
	if (got !== exp) begin
		$display("[FAIL] t=%0t %s: got %02h expected %02h", $time, name, got, exp);
		test_errors++;
		n_errors++;
	end
endtask

task automatic check_status(input logic [7:0] got, input logic [7:0] exp);
	n_checks++;
	if (got !== exp) begin
		$display("[FAIL] t=%0t status: got %08b expected %08b", $time, got, exp);
		test_errors++;
		n_errors++;
	end
endtask

task automatic check_request(input fdc_pkg::fdc_request_t got,
	input fdc_pkg::fdc_request_t exp);
	n_checks++;
	if (got !== exp) begin
		$display("[FAIL] t=%0t req: got %07h expected %07h", $time, got, exp);
		test_errors++;
		n_errors++;
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	n_checks++;
	if (got !== exp) begin
		$display("[FAIL] t=%0t %s: got %b expected %b", $time, name, got, exp);
		test_errors++;
		n_errors++;
	end
endtask

// --------------------------------------------------
// host bus, driven on the falling edge
// --------------------------------------------------
task automatic host_write(input logic [2:0] addr, input logic [7:0] data);
	@(negedge clk);
	host.wr    = 1'b1;
	host.addr  = addr;
	host.wdata = data;
	@(negedge clk);
	host.wr = 1'b0;
endtask

task automatic host_read(input logic [2:0] addr, output logic [7:0] data);
	@(negedge clk);
	host.rd   = 1'b1;
	host.addr = addr;
	@(negedge clk);
	host.rd = 1'b0;
	data    = rdata; // registered one edge after rd
endtask

task automatic wait_drq();
	int n;
	n = 0;
	while (!drq && n < WAIT_MAX) begin
		@(negedge clk);
		n++;
	end
	if (!drq)
		report_error("drq did not rise in time");
endtask

task automatic wait_irq();
	int n;
	n = 0;
	while (!irq && n < WAIT_MAX) begin
		@(negedge clk);
		n++;
	end
	if (!irq)
		report_error("irq did not rise in time");
endtask

// pops the oldest request seen by the workhorse
task automatic take_request(input fdc_pkg::fdc_request_t exp);
	if (req_q.size() == 0)
		report_error("no request reached the workhorse");
	else
		check_request(req_q.pop_front(), exp);
endtask

// serve drq for count bytes starting at byte first
task automatic read_pattern(input int first, input int count, input logic [7:0] trk,
	input logic [7:0] sec);
	logic [7:0] b;
	for (int i = first; i < first + count; i++) begin
		wait_drq();
		host_read(fdc_pkg::A_DATA, b);
		check_byte("data", b, pattern_byte(i, trk, sec));
	end
endtask

`endif

// File: tb_floppy.sv
`timescale 1ns/1ps

module tb_floppy;

	// each command as one byte plus the sector bytes
	localparam int PLANNED_BYTES = 48 + 5 * fdc_pkg::SECTOR_SIZE + fdc_pkg::READADDR_LEN + 8;
	localparam int CYCLE_LIMIT = PLANNED_BYTES *
		(fdc_pkg::FETCH_DELAY + 10 + fdc_pkg::WATCHDOG_TIME) + 10000;
	localparam int WAIT_MAX = 2 * fdc_pkg::SECTOR_SIZE + 200; // fill plus reply delay

	logic                  clk;
	logic                  cock;
	fdc_pkg::host_bus_t    host;
	logic [7:0]            rdata;
	logic                  irq;
	logic                  drq;
	logic                  req_valid;
	fdc_pkg::fdc_request_t req;
	logic                  reply_valid;
	fdc_pkg::fdc_reply_t   reply;
	fdc_pkg::buf_write_t   buf_wr;

	fdc_pkg::fdc_request_t req_q [$]; // requests seen by the workhorse
	int unsigned delays [64];         // reply latencies drawn up front
	logic        fail_next;           // next reply carries ok low
	int          n_tests;
	int          n_checks;
	int          n_errors;
	int          test_errors;
	string       test_name;

	floppy_top floppy_top_inst (
		.clk         (clk),
		.cock        (cock),
		.host        (host),
		.rdata       (rdata),
		.irq         (irq),
		.drq         (drq),
		.req_valid   (req_valid),
		.req         (req),
		.reply_valid (reply_valid),
		.reply       (reply),
		.buf_wr      (buf_wr)
	);

	`include "tb_floppy_tasks.svh"

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns
	end

	task automatic begin_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		n_tests++;
		if (test_errors == 0)
			$display("test %0d %-14s ok", n_tests, test_name);
		else
			$display("test %0d %-14s %0d errors", n_tests, test_name, test_errors);
	endtask

	task automatic write_buf(input int a, input logic [7:0] d);
		buf_wr.en   = 1'b1;
		buf_wr.addr = a[fdc_pkg::BUF_AW-1:0];
		buf_wr.data = d;
		@(negedge clk);
	endtask

	// type I command with its request, track and status checks
	task automatic run_type1(input logic [3:0] nib, input logic h, input logic [7:0] target);
		fdc_pkg::fdc_request_t exp;
		logic [7:0] v;
		logic [7:0] st;
		if (nib == fdc_pkg::CMD_SEEK)
			host_write(fdc_pkg::A_DATA, target);
		exp = expect_req(fdc_pkg::REQ_NOP, nib, m_sector);
		host_write(fdc_pkg::A_STATUS_CMD, {nib, h, 3'b000});
		apply_type1(nib, target);
		wait_irq();
		check_flag("irq", irq, 1'b1);
		take_request(exp);
		host_read(fdc_pkg::A_TRACK, v);
		check_byte("track", v, m_track);
		st = '0;
		st[fdc_pkg::SBIT_HEADLOAD]    = h;
		st[fdc_pkg::SBIT_LOST_TRACK0] = (m_head == 8'd0);
		host_read(fdc_pkg::A_STATUS_CMD, v);
		check_status(v, st);
	endtask

	// --------------------------------------------------
	// workhorse answers each request after a random delay
	// --------------------------------------------------
	initial begin : workhorse
		fdc_pkg::fdc_request_t r;
		int k;
		k = 0;
		forever begin
			@(negedge clk);
			if (req_valid) begin
				r = req;
				req_q.push_back(r);
				repeat (delays[k % 64]) @(negedge clk);
				k++;
				if (r.kind == fdc_pkg::REQ_READ && !fail_next) begin
					for (int i = 0; i < fdc_pkg::SECTOR_SIZE; i++)
						write_buf(i, pattern_byte(i, r.track, r.sector));
				end else if (r.kind == fdc_pkg::REQ_READADDR) begin
					write_buf(0, r.track);
					write_buf(1, {7'd0, r.side});
					write_buf(2, r.sector);
					write_buf(3, 8'h03);    // size code for 1024 bytes
					write_buf(4, 8'ha5);
					write_buf(5, 8'h5a);
				end
				buf_wr      = '0;
				reply_valid = 1'b1;
				reply.done  = 1'b1;
				reply.ok    = !fail_next;
				fail_next   = 1'b0;
				@(negedge clk);
				reply_valid = 1'b0;
				reply       = '0;
			end
		end
	end

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin : main
		logic [7:0] v;
		logic [7:0] st;
		logic [7:0] id [6];
		logic [3:0] nib;
		logic       upd;
		logic       more;
		int         pick;
		int         n;
		void'($urandom(63978));
		host        = '0;
		reply_valid = 1'b0;
		reply       = '0;
		buf_wr      = '0;
		fail_next   = 1'b0;
		cock        = 1'b1;
		{n_tests, n_checks, n_errors, test_errors} = '0;
		{m_track, m_sector, m_dir, m_drive, m_side} = '0;
		m_head = 8'hff; // unknown until restore
		foreach (delays[i])
			delays[i] = 1 + ($urandom % 40);
		repeat (8) @(negedge clk);
		cock = 1'b0;

		begin_test("reset");
		check_flag("irq", irq, 1'b0);
		check_flag("drq", drq, 1'b0);
		host_read(fdc_pkg::A_TRACK, v);
		check_byte("track", v, 8'h00);
		host_read(fdc_pkg::A_STATUS_CMD, v);
		check_status(v, 8'h00);
		run_type1(fdc_pkg::CMD_RESTORE, 1'b0, 8'd0); // request still shows ff
		end_test();

		begin_test("type I");
		m_drive = $urandom % 2;
		m_side  = $urandom % 2;
		host_write(fdc_pkg::A_CTL2, {5'd0, m_side, 1'b0, m_drive});
		for (int c = 0; c < 40; c++) begin
			pick = $urandom % 5;
			upd  = $urandom % 2;
			case (pick)
			0:       nib = fdc_pkg::CMD_RESTORE;
			1:       nib = fdc_pkg::CMD_SEEK;
			2:       nib = fdc_pkg::CMD_STEP | {3'd0, upd};
			3:       nib = fdc_pkg::CMD_STEP_IN | {3'd0, upd};
			default: nib = fdc_pkg::CMD_STEP_OUT | {3'd0, upd};
			endcase
			run_type1(nib, $urandom % 2, $urandom % 80);
		end
		end_test();

		begin_test("read sector");
		run_type1(fdc_pkg::CMD_SEEK, 1'b1, $urandom % 80);
		m_drive  = $urandom % 2;
		m_side   = $urandom % 2;
		m_sector = 1 + ($urandom % fdc_pkg::SECTORS_PER_TRACK);
		host_write(fdc_pkg::A_CTL2, {5'd0, m_side, 1'b0, m_drive});
		host_write(fdc_pkg::A_SECTOR, m_sector);
		host_write(fdc_pkg::A_STATUS_CMD, {fdc_pkg::CMD_READ_SEC, 4'h0});
		wait_drq();
		take_request(expect_req(fdc_pkg::REQ_READ, fdc_pkg::CMD_READ_SEC, m_sector));
		read_pattern(0, fdc_pkg::SECTOR_SIZE, m_head, m_sector);
		check_flag("irq", irq, 1'b1);
		host_read(fdc_pkg::A_STATUS_CMD, v);
		check_status(v, 8'h00);
		end_test();

		begin_test("multi sector");
		m_sector = 8'd3;
		host_write(fdc_pkg::A_SECTOR, m_sector);
		host_write(fdc_pkg::A_STATUS_CMD, {fdc_pkg::CMD_READ_MULTI, 4'h0});
		more = 1'b1;
		while (more) begin
			wait_drq();
			take_request(expect_req(fdc_pkg::REQ_READ, fdc_pkg::CMD_READ_MULTI, m_sector));
			read_pattern(0, fdc_pkg::SECTOR_SIZE, m_head, m_sector);
			more = (m_sector <= fdc_pkg::SECTORS_PER_TRACK); // goes one past the track
			if (more)
				m_sector++;
		end
		check_flag("irq", irq, 1'b1);
		repeat (50) @(negedge clk);
		if (req_q.size() != 0)
			report_error("multi sector read went on past the last sector");
		host_read(fdc_pkg::A_SECTOR, v);
		check_byte("sector", v, m_sector);
		host_read(fdc_pkg::A_STATUS_CMD, v);
		check_status(v, 8'h00);
		end_test();

		begin_test("read address");
		id = '{m_head, {7'd0, m_side}, m_sector, 8'h03, 8'ha5, 8'h5a};
		host_write(fdc_pkg::A_STATUS_CMD, {fdc_pkg::CMD_READ_ADDR, 4'h0});
		wait_drq();
		take_request(expect_req(fdc_pkg::REQ_READADDR, fdc_pkg::CMD_READ_ADDR, m_sector));
		for (int i = 0; i < fdc_pkg::READADDR_LEN; i++) begin
			wait_drq();
			host_read(fdc_pkg::A_DATA, v);
			check_byte("id", v, id[i]);
		end
		check_flag("irq", irq, 1'b1);
		host_read(fdc_pkg::A_STATUS_CMD, v);
		check_status(v, 8'h00);
		fail_next = 1'b1; // record not found
		host_write(fdc_pkg::A_STATUS_CMD, {fdc_pkg::CMD_READ_SEC, 4'h0});
		wait_irq();
		take_request(expect_req(fdc_pkg::REQ_READ, fdc_pkg::CMD_READ_SEC, m_sector));
		check_flag("drq", drq, 1'b0);
		st = '0;
		st[fdc_pkg::SBIT_SEEKERR] = 1'b1;
		host_read(fdc_pkg::A_STATUS_CMD, v);
		check_status(v, st);
		end_test();

		begin_test("lost data");
		m_sector = 8'd2;
		host_write(fdc_pkg::A_SECTOR, m_sector);
		host_write(fdc_pkg::A_STATUS_CMD, {fdc_pkg::CMD_READ_SEC, 4'h0});
		wait_drq();
		take_request(expect_req(fdc_pkg::REQ_READ, fdc_pkg::CMD_READ_SEC, m_sector));
		read_pattern(0, 5, m_head, m_sector);
		wait_drq();
		n = 0;
		while (drq && n <= fdc_pkg::WATCHDOG_TIME + 50) begin // byte 5 left alone
			@(negedge clk);
			n++;
		end
		if (drq)
			report_error("watchdog never dropped an unserved drq");
		else if (n < fdc_pkg::WATCHDOG_TIME)
			report_error("drq dropped before the watchdog time ran out");
		st = '0;
		st[fdc_pkg::SBIT_BUSY]        = 1'b1;
		st[fdc_pkg::SBIT_LOST_TRACK0] = 1'b1; // lost data in type II
		host_read(fdc_pkg::A_STATUS_CMD, v);
		check_status(v, st);
		read_pattern(6, 1, m_head, m_sector); // skipped byte stays skipped
		wait_drq(); // byte 7 pending when the interrupt lands
		host_write(fdc_pkg::A_STATUS_CMD, {fdc_pkg::CMD_FORCE_INT, 4'h0});
		repeat (2) @(negedge clk);
		check_flag("drq", drq, 1'b0);
		host_read(fdc_pkg::A_STATUS_CMD, v);
		check_status(v, 8'h00);
		end_test();

		$display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
		if (n_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// --------------------------------------------------
	// run limit
	// --------------------------------------------------
	initial begin : run_limit
		int cycles;
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the test sequence did not finish", cycles);
		$display("Test failures found");
		$finish;
	end

endmodule
